//--- verilog/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef enum logic [7:0] {
        OP_ASL_A     = 8'h0A,
        OP_ASL_ZPG   = 8'h06,
        OP_ASL_ZPG_X = 8'h16,
        OP_ASL_ABS   = 8'h0E,
        OP_LSR_A     = 8'h4A,
        OP_LSR_ZPG   = 8'h46,
        OP_LSR_ZPG_X = 8'h56,
        OP_LSR_ABS   = 8'h4E,
        OP_LDA_IMM   = 8'hA9,
        OP_LDX_IMM   = 8'hA2,
        OP_STA_ZPG   = 8'h85,
        OP_PHP       = 8'h08,
        OP_NOP       = 8'hEA
    } opcode_e;

    // Values follow opcode bits 4..2 where the column is unambiguous
    typedef enum logic [2:0] {
        MODE_IMM   = 3'b000,
        MODE_ZPG   = 3'b001,
        MODE_ACC   = 3'b010,
        MODE_ABS   = 3'b011,
        MODE_ZPG_X = 3'b101,
        MODE_IMPL  = 3'b110
    } addr_mode_e;

    typedef enum logic [3:0] {
        ST_FETCH    = 4'd0,
        ST_OPERAND  = 4'd1,
        ST_ABS_HIGH = 4'd2,
        ST_ADD_X    = 4'd3,
        ST_READ     = 4'd4,
        ST_MODIFY   = 4'd5,
        ST_WRITE    = 4'd6,
        ST_EXECUTE  = 4'd7,
        ST_PUSH     = 4'd8,
        ST_IDLE     = 4'd9
    } decode_state_e;

endpackage

`default_nettype wire

//--- verilog/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    typedef enum logic [1:0] {
        ALU_NOP = 2'b00, // Pass operand a
        ALU_ASL = 2'b01,
        ALU_LSR = 2'b10,
        ALU_ADD = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        LATCH_IDLE  = 2'b00,
        LATCH_LOAD  = 2'b01, // Take from the bus and keep
        LATCH_STORE = 2'b10  // Put the kept value on the bus
    } latch_op_e;

    typedef enum logic [1:0] {
        ADDR_PC    = 2'b00,
        ADDR_LATCH = 2'b01,
        ADDR_INDEX = 2'b10,
        ADDR_STACK = 2'b11
    } addr_sel_e;

    typedef enum logic {
        SRC_ACC = 1'b0,
        SRC_IDL = 1'b1
    } alu_src_e;

    localparam logic [2:0] flag_c  = 3'b001;
    localparam logic [2:0] flag_z  = 3'b010;
    localparam logic [2:0] flag_n  = 3'b100;
    localparam logic [7:0] sp_page = 8'h01;

endpackage

`default_nettype wire

//--- verilog/shift_alu.sv
`timescale 1ns/100ps
`default_nettype none

module shift_alu (
    input  logic [7:0]           a,
    input  logic [7:0]           b,
    input  logic                 carry_in,
    input  cpu_bus_pkg::alu_op_e alu_op,
    output logic [7:0]           result,
    output logic                 carry,
    output logic                 zero,
    output logic                 negative
);

    logic [8:0] sum;

    assign sum = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};

    always_comb begin
        result = a;
        carry  = carry_in;
        case (alu_op)
            cpu_bus_pkg::ALU_ASL: begin
                result = {a[6:0], 1'b0};
                carry  = a[7];
            end
            cpu_bus_pkg::ALU_LSR: begin
                result = {1'b0, a[7:1]}; // Negative always ends up clear
                carry  = a[0];
            end
            cpu_bus_pkg::ALU_ADD: begin
                result = sum[7:0];
                carry  = sum[8];
            end
            default: ;
        endcase
    end

    assign zero     = (result == 8'h00);
    assign negative = result[7];

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rdy,
    input  logic [7:0] alu_result,
    input  logic [7:0] data_in,
    input  logic       alu_carry,
    input  logic       alu_zero,
    input  logic       alu_negative,
    input  logic       a_load,
    input  logic       x_load,
    input  logic       sp_dec,
    input  logic [2:0] flag_mask,
    output logic [7:0] a,
    output logic [7:0] x,
    output logic [7:0] sp,
    output logic [7:0] status
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a      <= 8'h00;
            x      <= 8'h00;
            sp     <= 8'hFF;
            status <= 8'h20; // Bit 5 is hardwired high
        end else if (rdy) begin
            if (a_load)
                a <= alu_result;
            if (x_load)
                x <= data_in; // Only LDX immediate loads X
            if (sp_dec)
                sp <= sp - 8'd1;
            if (|(flag_mask & cpu_bus_pkg::flag_c))
                status[0] <= alu_carry;
            if (|(flag_mask & cpu_bus_pkg::flag_z))
                status[1] <= alu_zero;
            if (|(flag_mask & cpu_bus_pkg::flag_n))
                status[7] <= alu_negative;
        end
    end

    a_reserved_bit: assert property (@(posedge clk) disable iff (!arst_n) status[5]);

endmodule

`default_nettype wire

//--- verilog/address_unit.sv
`timescale 1ns/100ps
`default_nettype none

module address_unit #(
    parameter logic [15:0] reset_vector = 16'h0200
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   rdy,
    input  logic                   pc_inc,
    input  logic                   adl_load,
    input  logic                   adh_load,
    input  cpu_bus_pkg::addr_sel_e addr_sel,
    input  logic [7:0]             data_in,
    input  logic [7:0]             x,
    input  logic [7:0]             sp,
    output logic [15:0]            address
);

    logic [15:0] pc;
    logic [15:0] adr;
    logic [7:0]  index_low;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc <= reset_vector;
        else if (rdy && pc_inc)
            pc <= pc + 16'd1;
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (adl_load)
                adr <= {8'h00, data_in}; // Zero page until a high byte arrives
            else if (adh_load)
                adr[15:8] <= data_in;
        end
    end

    assign index_low = adr[7:0] + x; // Carry dropped, stays in page zero

    always_comb begin
        case (addr_sel)
            cpu_bus_pkg::ADDR_LATCH: address = adr;
            cpu_bus_pkg::ADDR_INDEX: address = {8'h00, index_low};
            cpu_bus_pkg::ADDR_STACK: address = {cpu_bus_pkg::sp_page, sp};
            default: address = pc;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/data_latches.sv
`timescale 1ns/100ps
`default_nettype none

module data_latches (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   rdy,
    input  logic [7:0]             data_in,
    input  logic [7:0]             alu_result,
    input  logic [7:0]             a,
    input  logic [7:0]             status,
    input  cpu_bus_pkg::latch_op_e idl_op,
    input  cpu_bus_pkg::latch_op_e dbuf_op,
    input  logic                   dbuf_src,
    output logic [7:0]             idl,
    output logic [7:0]             data_out
);

    logic [7:0] idl_q;
    logic [7:0] dbuf_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idl_q  <= 8'h00;
            dbuf_q <= 8'h00;
        end else if (rdy) begin
            if (idl_op == cpu_bus_pkg::LATCH_LOAD)
                idl_q <= data_in;
            if (dbuf_op == cpu_bus_pkg::LATCH_LOAD)
                dbuf_q <= dbuf_src ? a : alu_result;
        end
    end

    // Latch is transparent while loading
    assign idl = (idl_op == cpu_bus_pkg::LATCH_LOAD) ? data_in : idl_q;

    // On store, dbuf_src picks the status byte over the buffer
    assign data_out = (dbuf_op != cpu_bus_pkg::LATCH_STORE) ? 8'h00 :
                      dbuf_src ? status : dbuf_q;

endmodule

`default_nettype wire

//--- verilog/instruction_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instruction_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   rdy,
    input  logic [7:0]             data_in,
    output cpu_bus_pkg::alu_op_e   alu_op,
    output cpu_bus_pkg::alu_src_e  alu_src,
    output logic [2:0]             flag_mask,
    output logic                   a_load,
    output logic                   x_load,
    output logic                   sp_dec,
    output logic                   pc_inc,
    output logic                   adl_load,
    output logic                   adh_load,
    output cpu_bus_pkg::addr_sel_e addr_sel,
    output cpu_bus_pkg::latch_op_e idl_op,
    output cpu_bus_pkg::latch_op_e dbuf_op,
    output logic                   dbuf_src,
    output logic                   rw
);

    cpu_isa_pkg::decode_state_e state;
    cpu_isa_pkg::decode_state_e next_state;
    cpu_isa_pkg::opcode_e       opcode;
    cpu_isa_pkg::addr_mode_e    mode;
    cpu_isa_pkg::addr_mode_e    fetch_mode;
    logic                       fetch_known;
    cpu_bus_pkg::addr_sel_e     operand_sel;
    cpu_bus_pkg::alu_op_e       shift_op;

    function automatic logic is_known(input logic [7:0] op);
        logic known;
        case (op)
            cpu_isa_pkg::OP_ASL_A, cpu_isa_pkg::OP_ASL_ZPG, cpu_isa_pkg::OP_ASL_ZPG_X,
            cpu_isa_pkg::OP_ASL_ABS, cpu_isa_pkg::OP_LSR_A, cpu_isa_pkg::OP_LSR_ZPG,
            cpu_isa_pkg::OP_LSR_ZPG_X, cpu_isa_pkg::OP_LSR_ABS, cpu_isa_pkg::OP_LDA_IMM,
            cpu_isa_pkg::OP_LDX_IMM, cpu_isa_pkg::OP_STA_ZPG, cpu_isa_pkg::OP_PHP,
            cpu_isa_pkg::OP_NOP: known = 1'b1;
            default: known = 1'b0;
        endcase
        return known;
    endfunction

    // Column 010 mixes accumulator, immediate and implied forms
    function automatic cpu_isa_pkg::addr_mode_e mode_of(input logic [7:0] op);
        cpu_isa_pkg::addr_mode_e m;
        case (op[4:2])
            3'b000: m = cpu_isa_pkg::MODE_IMM;
            3'b001: m = cpu_isa_pkg::MODE_ZPG;
            3'b011: m = cpu_isa_pkg::MODE_ABS;
            3'b101: m = cpu_isa_pkg::MODE_ZPG_X;
            3'b010: m = op[0] ? cpu_isa_pkg::MODE_IMM :
                        (op[1] && !op[7]) ? cpu_isa_pkg::MODE_ACC : cpu_isa_pkg::MODE_IMPL;
            default: m = cpu_isa_pkg::MODE_IMPL;
        endcase
        return m;
    endfunction

    assign fetch_known = is_known(data_in);
    assign fetch_mode  = fetch_known ? mode_of(data_in) : cpu_isa_pkg::MODE_IMPL;
    assign operand_sel = (mode == cpu_isa_pkg::MODE_ZPG_X) ? cpu_bus_pkg::ADDR_INDEX :
                                                             cpu_bus_pkg::ADDR_LATCH;
    assign shift_op    = opcode[6] ? cpu_bus_pkg::ALU_LSR : cpu_bus_pkg::ALU_ASL; // 0x4x/0x5x

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= cpu_isa_pkg::ST_FETCH;
            opcode <= cpu_isa_pkg::OP_NOP;
            mode   <= cpu_isa_pkg::MODE_IMPL;
        end else if (rdy) begin
            state <= next_state;
            if (state == cpu_isa_pkg::ST_FETCH) begin
                opcode <= fetch_known ? cpu_isa_pkg::opcode_e'(data_in) : cpu_isa_pkg::OP_NOP;
                mode   <= fetch_mode;
            end
        end
    end

    always_comb begin
        next_state = state;
        alu_op     = cpu_bus_pkg::ALU_NOP;
        alu_src    = cpu_bus_pkg::SRC_ACC;
        flag_mask  = 3'b000;
        a_load     = 1'b0;
        x_load     = 1'b0;
        sp_dec     = 1'b0;
        pc_inc     = 1'b0;
        adl_load   = 1'b0;
        adh_load   = 1'b0;
        addr_sel   = cpu_bus_pkg::ADDR_PC;
        idl_op     = cpu_bus_pkg::LATCH_IDLE;
        dbuf_op    = cpu_bus_pkg::LATCH_IDLE;
        dbuf_src   = 1'b0;
        rw         = 1'b1;
        case (state)
            cpu_isa_pkg::ST_FETCH: begin
                pc_inc = 1'b1;
                case (fetch_mode)
                    cpu_isa_pkg::MODE_ACC: next_state = cpu_isa_pkg::ST_EXECUTE;
                    cpu_isa_pkg::MODE_IMPL: begin
                        next_state = (data_in == cpu_isa_pkg::OP_PHP) ? cpu_isa_pkg::ST_PUSH :
                                                                       cpu_isa_pkg::ST_IDLE;
                    end
                    default: next_state = cpu_isa_pkg::ST_OPERAND;
                endcase
            end
            cpu_isa_pkg::ST_OPERAND: begin
                pc_inc = 1'b1;
                idl_op = cpu_bus_pkg::LATCH_LOAD; // Operand byte passes through to the ALU
                if (mode == cpu_isa_pkg::MODE_IMM) begin
                    alu_src    = cpu_bus_pkg::SRC_IDL;
                    flag_mask  = cpu_bus_pkg::flag_z | cpu_bus_pkg::flag_n;
                    a_load     = (opcode == cpu_isa_pkg::OP_LDA_IMM);
                    x_load     = (opcode == cpu_isa_pkg::OP_LDX_IMM);
                    next_state = cpu_isa_pkg::ST_FETCH;
                end else if (opcode == cpu_isa_pkg::OP_STA_ZPG) begin
                    adl_load   = 1'b1;
                    dbuf_op    = cpu_bus_pkg::LATCH_LOAD;
                    dbuf_src   = 1'b1; // Capture A for the write
                    next_state = cpu_isa_pkg::ST_WRITE;
                end else begin
                    adl_load = 1'b1;
                    case (mode)
                        cpu_isa_pkg::MODE_ZPG: next_state = cpu_isa_pkg::ST_READ;
                        cpu_isa_pkg::MODE_ZPG_X: next_state = cpu_isa_pkg::ST_ADD_X;
                        default: next_state = cpu_isa_pkg::ST_ABS_HIGH;
                    endcase
                end
            end
            cpu_isa_pkg::ST_ABS_HIGH: begin
                pc_inc     = 1'b1;
                adh_load   = 1'b1;
                next_state = cpu_isa_pkg::ST_READ;
            end
            cpu_isa_pkg::ST_ADD_X: begin
                addr_sel   = cpu_bus_pkg::ADDR_LATCH; // Dummy read of the base
                alu_src    = cpu_bus_pkg::SRC_IDL;
                alu_op     = cpu_bus_pkg::ALU_ADD;
                next_state = cpu_isa_pkg::ST_READ;
            end
            cpu_isa_pkg::ST_READ: begin
                addr_sel   = operand_sel;
                idl_op     = cpu_bus_pkg::LATCH_LOAD;
                next_state = cpu_isa_pkg::ST_MODIFY;
            end
            cpu_isa_pkg::ST_MODIFY: begin
                addr_sel   = operand_sel;
                alu_src    = cpu_bus_pkg::SRC_IDL;
                alu_op     = shift_op;
                flag_mask  = cpu_bus_pkg::flag_c | cpu_bus_pkg::flag_z | cpu_bus_pkg::flag_n;
                dbuf_op    = cpu_bus_pkg::LATCH_LOAD;
                next_state = cpu_isa_pkg::ST_WRITE;
            end
            cpu_isa_pkg::ST_WRITE: begin
                addr_sel   = operand_sel;
                dbuf_op    = cpu_bus_pkg::LATCH_STORE;
                rw         = 1'b0;
                next_state = cpu_isa_pkg::ST_FETCH;
            end
            cpu_isa_pkg::ST_EXECUTE: begin
                alu_op     = shift_op;
                flag_mask  = cpu_bus_pkg::flag_c | cpu_bus_pkg::flag_z | cpu_bus_pkg::flag_n;
                a_load     = 1'b1;
                next_state = cpu_isa_pkg::ST_FETCH;
            end
            cpu_isa_pkg::ST_PUSH: begin
                addr_sel   = cpu_bus_pkg::ADDR_STACK;
                dbuf_op    = cpu_bus_pkg::LATCH_STORE;
                dbuf_src   = 1'b1; // Status straight onto the bus
                rw         = 1'b0;
                sp_dec     = 1'b1;
                next_state = cpu_isa_pkg::ST_FETCH;
            end
            default: next_state = cpu_isa_pkg::ST_FETCH;
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
        state inside {cpu_isa_pkg::ST_FETCH, cpu_isa_pkg::ST_OPERAND, cpu_isa_pkg::ST_ABS_HIGH,
                      cpu_isa_pkg::ST_ADD_X, cpu_isa_pkg::ST_READ, cpu_isa_pkg::ST_MODIFY,
                      cpu_isa_pkg::ST_WRITE, cpu_isa_pkg::ST_EXECUTE, cpu_isa_pkg::ST_PUSH,
                      cpu_isa_pkg::ST_IDLE});

    a_write_state: assert property (@(posedge clk) disable iff (!arst_n)
        !rw |-> state inside {cpu_isa_pkg::ST_WRITE, cpu_isa_pkg::ST_PUSH});

endmodule

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
    parameter logic [15:0] reset_vector = 16'h0200
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic [7:0]  data_in,
    output logic [15:0] address,
    output logic [7:0]  data_out,
    output logic        rw
);

    cpu_bus_pkg::alu_op_e   alu_op;
    cpu_bus_pkg::alu_src_e  alu_src;
    cpu_bus_pkg::addr_sel_e addr_sel;
    cpu_bus_pkg::latch_op_e idl_op;
    cpu_bus_pkg::latch_op_e dbuf_op;
    logic [2:0]             flag_mask;
    logic                   a_load;
    logic                   x_load;
    logic                   sp_dec;
    logic                   pc_inc;
    logic                   adl_load;
    logic                   adh_load;
    logic                   dbuf_src;
    logic [7:0]             alu_a;
    logic [7:0]             alu_result;
    logic                   alu_carry;
    logic                   alu_zero;
    logic                   alu_negative;
    logic [7:0]             a;
    logic [7:0]             x;
    logic [7:0]             sp;
    logic [7:0]             status;
    logic [7:0]             idl;

    assign alu_a = (alu_src == cpu_bus_pkg::SRC_IDL) ? idl : a;

    instruction_decode i_instruction_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .rdy       (rdy),
        .data_in   (data_in),
        .alu_op    (alu_op),
        .alu_src   (alu_src),
        .flag_mask (flag_mask),
        .a_load    (a_load),
        .x_load    (x_load),
        .sp_dec    (sp_dec),
        .pc_inc    (pc_inc),
        .adl_load  (adl_load),
        .adh_load  (adh_load),
        .addr_sel  (addr_sel),
        .idl_op    (idl_op),
        .dbuf_op   (dbuf_op),
        .dbuf_src  (dbuf_src),
        .rw        (rw)
    );

    shift_alu i_shift_alu (
        .a        (alu_a),
        .b        (x),
        .carry_in (1'b0), // Index sums add without carry
        .alu_op   (alu_op),
        .result   (alu_result),
        .carry    (alu_carry),
        .zero     (alu_zero),
        .negative (alu_negative)
    );

    register_file i_register_file (
        .clk          (clk),
        .arst_n       (arst_n),
        .rdy          (rdy),
        .alu_result   (alu_result),
        .data_in      (data_in),
        .alu_carry    (alu_carry),
        .alu_zero     (alu_zero),
        .alu_negative (alu_negative),
        .a_load       (a_load),
        .x_load       (x_load),
        .sp_dec       (sp_dec),
        .flag_mask    (flag_mask),
        .a            (a),
        .x            (x),
        .sp           (sp),
        .status       (status)
    );

    address_unit #(
        .reset_vector (reset_vector)
    ) i_address_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .rdy      (rdy),
        .pc_inc   (pc_inc),
        .adl_load (adl_load),
        .adh_load (adh_load),
        .addr_sel (addr_sel),
        .data_in  (data_in),
        .x        (x),
        .sp       (sp),
        .address  (address)
    );

    data_latches i_data_latches (
        .clk        (clk),
        .arst_n     (arst_n),
        .rdy        (rdy),
        .data_in    (data_in),
        .alu_result (alu_result),
        .a          (a),
        .status     (status),
        .idl_op     (idl_op),
        .dbuf_op    (dbuf_op),
        .dbuf_src   (dbuf_src),
        .idl        (idl),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

//--- verification/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;

    localparam logic [15:0] start_addr    = 16'h0200;
    localparam int          write_timeout = 20000; // Cycles for the whole program

    logic        clk;
    logic        arst_n;
    logic        rdy;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        rw;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    logic [15:0] load_ptr;
    logic [7:0]  ref_a;
    logic [7:0]  ref_x;
    logic [7:0]  ref_sp;
    logic        ref_c;
    logic        ref_z;
    logic        ref_n;
    int          writes_seen;
    int          wait_cycles;

    cpu_core #(
        .reset_vector (start_addr)
    ) i_cpu_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .rdy      (rdy),
        .data_in  (data_in),
        .address  (address),
        .data_out (data_out),
        .rw       (rw)
    );

    assign data_in = mem[address]; // Asynchronous read

    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    function automatic logic is_listed_opcode(input logic [7:0] op);
        return op inside {cpu_isa_pkg::OP_ASL_A, cpu_isa_pkg::OP_ASL_ZPG,
                          cpu_isa_pkg::OP_ASL_ZPG_X, cpu_isa_pkg::OP_ASL_ABS,
                          cpu_isa_pkg::OP_LSR_A, cpu_isa_pkg::OP_LSR_ZPG,
                          cpu_isa_pkg::OP_LSR_ZPG_X, cpu_isa_pkg::OP_LSR_ABS,
                          cpu_isa_pkg::OP_LDA_IMM, cpu_isa_pkg::OP_LDX_IMM,
                          cpu_isa_pkg::OP_STA_ZPG, cpu_isa_pkg::OP_PHP, cpu_isa_pkg::OP_NOP};
    endfunction

    function automatic logic [7:0] random_unknown();
        logic [7:0] op;
        op = 8'($urandom);
        while (is_listed_opcode(op))
            op = 8'($urandom);
        return op;
    endfunction

    task automatic emit(input logic [7:0] value);
        mem[load_ptr]     = value;
        ref_mem[load_ptr] = value;
        load_ptr          = load_ptr + 16'd1;
    endtask

    task automatic emit_with_operand(input logic [7:0] op);
        emit(op);
        emit(8'($urandom));
    endtask

    // Targets stay in 0x1000..0x7FFF, clear of stack and program
    task automatic emit_absolute(input logic [7:0] op);
        emit(op);
        emit(8'($urandom));
        emit(8'h10 + 8'($urandom % 112));
    endtask

    task automatic emit_instruction(input int unsigned kind);
        case (kind)
            0: emit_with_operand(cpu_isa_pkg::OP_ASL_ZPG);
            1: emit_with_operand(cpu_isa_pkg::OP_LSR_ZPG);
            2: emit_with_operand(cpu_isa_pkg::OP_ASL_ZPG_X);
            3: emit_with_operand(cpu_isa_pkg::OP_LSR_ZPG_X);
            4: emit_with_operand(cpu_isa_pkg::OP_STA_ZPG);
            5: emit_with_operand(cpu_isa_pkg::OP_LDA_IMM);
            6: emit_with_operand(cpu_isa_pkg::OP_LDX_IMM);
            7: emit_absolute(cpu_isa_pkg::OP_ASL_ABS);
            8: emit_absolute(cpu_isa_pkg::OP_LSR_ABS);
            9: emit(cpu_isa_pkg::OP_NOP);
            10: emit(random_unknown());
            default: emit(cpu_isa_pkg::OP_PHP);
        endcase
    endtask

    task automatic fill_memory();
        logic [15:0] adr;
        for (int i = 0; i < 65536; i++) begin
            adr = 16'(i);
            if (adr < 16'h0100)
                mem[adr] = 8'($urandom); // Random zero page
            else if (adr >= start_addr && adr < 16'h1000)
                mem[adr] = cpu_isa_pkg::OP_NOP; // Endless NOP run past the program
            else
                mem[adr] = adr[15:8] ^ {adr[6:0], adr[7]} ^ 8'hA5;
            ref_mem[adr] = mem[adr];
        end
    endtask

    task automatic build_program();
        logic [7:0] flag_vals [4];
        logic [7:0] value;
        flag_vals = '{8'h80, 8'h01, 8'hC0, 8'h00}; // Carry, zero and negative corners
        load_ptr  = start_addr;
        emit(random_unknown());
        emit(cpu_isa_pkg::OP_NOP);
        for (int i = 0; i < 8; i++) begin
            value = (i < 4) ? flag_vals[i] : 8'($urandom);
            emit(cpu_isa_pkg::OP_LDA_IMM);
            emit(value);
            emit(cpu_isa_pkg::OP_ASL_A);
            emit(cpu_isa_pkg::OP_PHP);
            emit(cpu_isa_pkg::OP_LDA_IMM);
            emit(value);
            emit(cpu_isa_pkg::OP_LSR_A);
            emit(cpu_isa_pkg::OP_PHP);
        end
        emit_with_operand(cpu_isa_pkg::OP_LDX_IMM);
        for (int unsigned k = 0; k < 12; k++)
            emit_instruction(k); // Every form at least once
        for (int i = 0; i < 40; i++)
            emit_instruction($urandom % 12);
        emit(cpu_isa_pkg::OP_PHP); // Final flags
    endtask

    task automatic set_zn(input logic [7:0] value);
        ref_z = (value == 8'h00);
        ref_n = value[7];
    endtask

    task automatic shift_value(input logic right, input logic [7:0] value,
                               output logic [7:0] result);
        if (right) begin
            result = value >> 1;
            ref_c  = value[0];
        end else begin
            result = value << 1;
            ref_c  = value[7];
        end
        set_zn(result);
    endtask

    function automatic logic [7:0] status_byte();
        return {ref_n, 1'b0, 1'b1, 3'b000, ref_z, ref_c}; // Bit 5 reads as one
    endfunction

    task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
        ref_mem[addr] = data;
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic modify_memory(input logic right, input logic [15:0] ea);
        logic [7:0] value;
        shift_value(right, ref_mem[ea], value);
        expect_write(ea, value);
    endtask

    task automatic run_model();
        logic [15:0] pc;
        logic [7:0]  op;
        logic [7:0]  opd;
        logic [7:0]  value;
        pc     = start_addr;
        ref_a  = 8'h00;
        ref_x  = 8'h00;
        ref_sp = 8'hFF;
        ref_c  = 1'b0;
        ref_z  = 1'b0;
        ref_n  = 1'b0;
        while (pc != load_ptr) begin
            op  = ref_mem[pc];
            opd = ref_mem[pc + 16'd1];
            pc  = pc + 16'd1;
            case (op)
                cpu_isa_pkg::OP_ASL_A, cpu_isa_pkg::OP_LSR_A: begin
                    shift_value(op == cpu_isa_pkg::OP_LSR_A, ref_a, value);
                    ref_a = value;
                end
                cpu_isa_pkg::OP_LDA_IMM: begin
                    ref_a = opd;
                    set_zn(opd);
                    pc = pc + 16'd1;
                end
                cpu_isa_pkg::OP_LDX_IMM: begin
                    ref_x = opd;
                    set_zn(opd);
                    pc = pc + 16'd1;
                end
                cpu_isa_pkg::OP_STA_ZPG: begin
                    expect_write({8'h00, opd}, ref_a);
                    pc = pc + 16'd1;
                end
                cpu_isa_pkg::OP_PHP: begin
                    expect_write({8'h01, ref_sp}, status_byte());
                    ref_sp = ref_sp - 8'd1;
                end
                cpu_isa_pkg::OP_ASL_ZPG, cpu_isa_pkg::OP_LSR_ZPG: begin
                    modify_memory(op == cpu_isa_pkg::OP_LSR_ZPG, {8'h00, opd});
                    pc = pc + 16'd1;
                end
                cpu_isa_pkg::OP_ASL_ZPG_X, cpu_isa_pkg::OP_LSR_ZPG_X: begin
                    value = opd + ref_x; // Wraps inside page zero
                    modify_memory(op == cpu_isa_pkg::OP_LSR_ZPG_X, {8'h00, value});
                    pc = pc + 16'd1;
                end
                cpu_isa_pkg::OP_ASL_ABS, cpu_isa_pkg::OP_LSR_ABS: begin
                    modify_memory(op == cpu_isa_pkg::OP_LSR_ABS, {ref_mem[pc + 16'd1], opd});
                    pc = pc + 16'd2;
                end
                default: ; // NOP and unknown opcodes take one byte
            endcase
        end
    endtask

    // Memory write port, checked against the model on every write
    always @(posedge clk) begin
        if (arst_n && rdy && !rw) begin
            assert (writes_seen < exp_addr.size())
                else report_failure($sformatf("Error at time %0t: unexpected write to %h",
                                              $time, address));
            assert (address == exp_addr[writes_seen])
                else report_failure($sformatf("Error at time %0t: write address is %h, expected %h",
                                              $time, address, exp_addr[writes_seen]));
            assert (data_out == exp_data[writes_seen])
                else report_failure($sformatf("Error at time %0t: data to %h is %h, expected %h",
                                              $time, address, data_out, exp_data[writes_seen]));
            mem[address] = data_out;
            writes_seen  = writes_seen + 1;
        end
    end

    always @(posedge clk) begin
        if (arst_n)
            rdy <= ($urandom % 4) != 0; // About one stall cycle in four
    end

    initial begin
        void'($urandom(70));
        clk         = 1'b0;
        arst_n      = 1'b0;
        rdy         = 1'b1;
        writes_seen = 0;
        fill_memory();
        build_program();
        run_model();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            assert (rw == 1'b1)
                else report_failure($sformatf("Error at time %0t: rw is %b in reset, expected 1",
                                              $time, rw));
        end
        arst_n <= 1'b1;
        @(posedge clk);
        assert (address == start_addr)
            else report_failure($sformatf("Error at time %0t: first address is %h, expected %h",
                                          $time, address, start_addr));
        assert (rw == 1'b1)
            else report_failure($sformatf("Error at time %0t: first rw is %b, expected 1",
                                          $time, rw));
        wait_cycles = 0;
        while (writes_seen < exp_addr.size() && wait_cycles < write_timeout) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (writes_seen < exp_addr.size()) begin
            report_failure("Timed out waiting for the last expected write");
        end else begin
            for (int i = 0; i < 32; i++)
                @(posedge clk); // NOP tail must stay silent
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/shift_alu.sv
verilog/register_file.sv
verilog/address_unit.sv
verilog/data_latches.sv
verilog/instruction_decode.sv
verilog/cpu_core.sv
verification/tb_cpu_core.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f project.f \
		--top-module tb_cpu_core -Mdir $(OBJ_DIR) -o Vtb_cpu_core

run: compile
	./$(OBJ_DIR)/Vtb_cpu_core | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || { echo "No pass line in sim.log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) sim.log
